// File: design/rtg_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths for the RTG display path. Pixel words are RGB555 with
// bit 15 ignored; the fetch pacing counter is limited to 16 clocks.
////////////////////////////////////////////////////////////////////////////

package rtg_pkg;

	// One word from the pixel FIFO, x:R5:G5:B5
	typedef logic [15:0] pix_word_t;

	// One VGA colour channel
	typedef logic [7:0] chan_t;

	// Clocks per pixel fetch, minus one
	typedef logic [3:0] pix_width_t;

	// Lines of vertical blank added after chipset vblank
	typedef logic [6:0] vb_lines_t;

	// Top two channel bits forced by the OSD
	typedef logic [1:0] osd_colour_t;

	// Native pixel strobe divider width
	// 8 clocks per pixel, 4 in 15 kHz mode
	localparam int NATIVE_STROBE_W = 3;

endpackage

// File: design/rtg_pixel_timing.sv
////////////////////////////////////////////////////////////////////////////
// Pixel fetch pacing for RTG and the native pixel strobe. Mode inputs are
// static levels; blank is held after reset until the first vblank ends.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module rtg_pixel_timing (
	input  logic                CLK_114,
	input  logic                arst_n,
	input  logic                rtg_ena,       // RTG screen on
	input  rtg_pkg::pix_width_t pixel_width,   // Clocks per fetch - 1
	input  rtg_pkg::vb_lines_t  vb_end,        // Extra blank lines
	input  logic                rtg_ext,       // One more fetch past blank
	input  logic                scan_15khz,    // Scandoubler off
	input  logic                hs,
	input  logic                hblank,
	input  logic                vblank,
	output logic                pop,           // Fetch next FIFO word
	output logic                blank_d2,      // Blank, two clocks late
	output logic                native_strobe  // Native pixel pulse
);

	////////////////////////////////////////////////////////////////////////////
	// Blanking
	////////////////////////////////////////////////////////////////////////////

	logic               blank;
	logic               blank_d;
	logic               vblank_ext;    // Chipset vblank plus vb_end lines
	rtg_pkg::vb_lines_t vb_ctr;        // Lines seen since vblank fell
	logic               hs_d;
	logic               hs_rise;

	assign hs_rise = hs & ~hs_d;
	assign blank   = vblank_ext | hblank;

	// The OS vblank is too short for the RTG frame, so stretch it here
	always_ff @(posedge CLK_114 or negedge arst_n) begin
		if (!arst_n) begin
			hs_d       <= 1'b0;
			vblank_ext <= 1'b1;            // Blanked until counted out
			vb_ctr     <= '0;
			blank_d    <= 1'b1;
			blank_d2   <= 1'b1;
		end else begin
			hs_d     <= hs;
			blank_d  <= blank;
			blank_d2 <= blank_d;
			if (vblank) begin
				vblank_ext <= 1'b1;
				vb_ctr     <= '0;
			end else if (vb_ctr == vb_end) begin
				vblank_ext <= 1'b0;        // Count reached, open the frame
			end else if (hs_rise) begin
				vb_ctr <= vb_ctr + 1'b1;   // One more line
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Fetch counter
	////////////////////////////////////////////////////////////////////////////

	rtg_pkg::pix_width_t fetch_ctr;

	// rtg_ext lets one fetch through in the first blanked clock
	assign pop = rtg_ena && (!blank || (!blank_d && rtg_ext)) && (fetch_ctr == pixel_width);

	always_ff @(posedge CLK_114 or negedge arst_n) begin
		if (!arst_n) begin
			fetch_ctr <= '0;
		end else if (blank || pop) begin
			fetch_ctr <= '0;               // Restart each pixel and in blank
		end else begin
			fetch_ctr <= fetch_ctr + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Native pixel strobe
	////////////////////////////////////////////////////////////////////////////

	logic [rtg_pkg::NATIVE_STROBE_W-1:0] nat_ctr;

	assign native_strobe = (nat_ctr == '0);

	always_ff @(posedge CLK_114 or negedge arst_n) begin
		if (!arst_n) begin
			nat_ctr <= '0;
		end else if (scan_15khz) begin
			// Step by two on even values, halves the period
			nat_ctr <= {nat_ctr[rtg_pkg::NATIVE_STROBE_W-1:1], 1'b0} + 2'd2;
		end else begin
			nat_ctr <= nat_ctr + 1'b1;
		end
	end

endmodule

// File: design/rtg_pixel_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Pixel word FIFO refilled from memory in bursts of BURST_LEN words.
// Depth must be a power of two and BURST_LEN at most half of it.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module rtg_pixel_fifo #(
	parameter int FIFO_DEPTH_LOG2 = 4,
	parameter int BURST_LEN       = 4
) (
	input  logic               CLK_114,
	input  logic               arst_n,
	input  logic               flush,      // Empty and stop fetching
	input  logic               fill,       // One word from memory
	input  rtg_pkg::pix_word_t fill_data,
	input  logic               pop,        // Pixel fetch strobe
	output logic               fetch_req,  // Burst wanted, level
	output rtg_pkg::pix_word_t head_word   // Last popped word
);

	typedef logic [FIFO_DEPTH_LOG2:0]   cnt_t;
	typedef logic [FIFO_DEPTH_LOG2-1:0] ptr_t;

	localparam cnt_t DEPTH = cnt_t'(2 ** FIFO_DEPTH_LOG2);
	localparam cnt_t BURST = cnt_t'(BURST_LEN);

	rtg_pkg::pix_word_t mem [2 ** FIFO_DEPTH_LOG2];
	ptr_t               wr_ptr;
	ptr_t               rd_ptr;
	cnt_t               count;        // Words held
	cnt_t               burst_ctr;    // Words taken in this burst
	logic               push;
	logic               do_pop;

	// Fills outside a request, or during flush, are dropped
	assign push   = fill && fetch_req && !flush;
	assign do_pop = pop && (count != '0) && !flush;

	always_ff @(posedge CLK_114) begin
		if (push) begin
			mem[wr_ptr] <= fill_data;
		end
	end

	always_ff @(posedge CLK_114 or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			burst_ctr <= '0;
			fetch_req <= 1'b0;
			head_word <= '0;
		end else if (flush) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			burst_ctr <= '0;               // Abandon any open burst
			fetch_req <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				head_word <= mem[rd_ptr];  // Valid the clock after pop
				rd_ptr    <= rd_ptr + 1'b1;
			end
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Burst bookkeeping
			if (fetch_req) begin
				if (push) begin
					if (burst_ctr == BURST - cnt_t'(1)) begin
						fetch_req <= 1'b0;     // Last word, drop for a clock
						burst_ctr <= '0;
					end else begin
						burst_ctr <= burst_ctr + 1'b1;
					end
				end
			end else if (DEPTH - count >= BURST) begin
				fetch_req <= 1'b1;         // Room for a whole burst
			end
		end
	end

endmodule

// File: design/rtg_colour_out.sv
////////////////////////////////////////////////////////////////////////////
// Final VGA stage, RGB555 expansion or native colour, then OSD overlay.
// The OSD window is applied after the register, unregistered.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module rtg_colour_out (
	input  logic               CLK_114,
	input  logic               arst_n,
	input  logic               rtg_ena,
	input  logic               blank_d2,
	input  logic               pop,
	input  logic               native_strobe,
	input  rtg_pkg::pix_word_t head_word,
	input  rtg_pkg::chan_t     red,
	input  rtg_pkg::chan_t     green,
	input  rtg_pkg::chan_t     blue,
	input  logic               hs,
	input  logic               vs,
	input  logic               cs,
	input  logic               hsyncpol,
	input  logic               vsyncpol,
	input  logic               osd_window,  // OSD covers this pixel
	input  logic               osd_pixel,   // OSD foreground
	output logic               vga_pixel,   // New pixel pulse
	output rtg_pkg::chan_t     vga_r,
	output rtg_pkg::chan_t     vga_g,
	output rtg_pkg::chan_t     vga_b,
	output logic               vga_hs,
	output logic               vga_vs,
	output logic               vga_cs
);

	// 5 to 8 bits, top three repeated below
	function automatic rtg_pkg::chan_t expand5(input logic [4:0] field);
		return {field, field[4:2]};
	endfunction

	rtg_pkg::chan_t      red_reg;
	rtg_pkg::chan_t      green_reg;
	rtg_pkg::chan_t      blue_reg;
	logic                hs_reg;
	logic                vs_reg;
	logic                cs_reg;
	logic                pop_d;
	logic                pop_d2;
	logic                rtg_sel;
	rtg_pkg::osd_colour_t osd_rg;
	rtg_pkg::osd_colour_t osd_b;

	assign rtg_sel = rtg_ena && !blank_d2;

	always_ff @(posedge CLK_114) begin
		red_reg   <= rtg_sel ? expand5(head_word[14:10]) : red;
		green_reg <= rtg_sel ? expand5(head_word[9:5]) : green;
		blue_reg  <= rtg_sel ? expand5(head_word[4:0]) : blue;
	end

	always_ff @(posedge CLK_114 or negedge arst_n) begin
		if (!arst_n) begin
			hs_reg <= 1'b0;
			vs_reg <= 1'b0;
			cs_reg <= 1'b0;
			pop_d  <= 1'b0;
			pop_d2 <= 1'b0;
		end else begin
			hs_reg <= hs;
			vs_reg <= vs;
			cs_reg <= cs;
			pop_d  <= pop;
			pop_d2 <= pop_d;               // Lines up with channel registers
		end
	end

	assign vga_pixel = rtg_ena ? pop_d2 : native_strobe;

	////////////////////////////////////////////////////////////////////////////
	// OSD overlay and sync polarity
	////////////////////////////////////////////////////////////////////////////

	assign osd_rg = osd_pixel ? 2'b11 : 2'b00;
	assign osd_b  = osd_pixel ? 2'b11 : 2'b10;   // Bluish OSD background

	assign vga_r = osd_window ? {osd_rg, red_reg[7:2]} : red_reg;
	assign vga_g = osd_window ? {osd_rg, green_reg[7:2]} : green_reg;
	assign vga_b = osd_window ? {osd_b, blue_reg[7:2]} : blue_reg;

	assign vga_cs = cs_reg;                      // Composite sync as is
	assign vga_hs = hsyncpol ^ hs_reg;
	assign vga_vs = vsyncpol ^ vs_reg;

endmodule

// File: design/rtg_video_out.sv
////////////////////////////////////////////////////////////////////////////
// RTG display path top. Memory answers fetch_req with one-cycle fill
// strobes; the display side never stalls.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module rtg_video_out #(
	parameter int FIFO_DEPTH_LOG2 = 4,     // 16 words
	parameter int BURST_LEN       = 4      // Words per fetch request
) (
	input  logic                CLK_114,
	input  logic                arst_n,
	input  logic                rtg_ena,
	input  rtg_pkg::pix_width_t pixel_width,
	input  rtg_pkg::vb_lines_t  vb_end,
	input  logic                rtg_ext,
	input  logic                scan_15khz,
	input  rtg_pkg::chan_t      red,
	input  rtg_pkg::chan_t      green,
	input  rtg_pkg::chan_t      blue,
	input  logic                hs,
	input  logic                vs,
	input  logic                cs,
	input  logic                hsyncpol,
	input  logic                vsyncpol,
	input  logic                hblank,
	input  logic                vblank,
	input  logic                osd_window,
	input  logic                osd_pixel,
	input  logic                fill,
	input  rtg_pkg::pix_word_t  fill_data,
	output logic                fetch_req,
	output logic                vga_pixel,
	output rtg_pkg::chan_t      vga_r,
	output rtg_pkg::chan_t      vga_g,
	output rtg_pkg::chan_t      vga_b,
	output logic                vga_hs,
	output logic                vga_vs,
	output logic                vga_cs
);

	logic               pop;
	logic               blank_d2;
	logic               native_strobe;
	logic               flush;
	rtg_pkg::pix_word_t head_word;

	// Restart the stream each frame and whenever RTG is off
	assign flush = vblank | ~rtg_ena;

	rtg_pixel_timing u_timing (
		.CLK_114      (CLK_114),
		.arst_n       (arst_n),
		.rtg_ena      (rtg_ena),
		.pixel_width  (pixel_width),
		.vb_end       (vb_end),
		.rtg_ext      (rtg_ext),
		.scan_15khz   (scan_15khz),
		.hs           (hs),
		.hblank       (hblank),
		.vblank       (vblank),
		.pop          (pop),
		.blank_d2     (blank_d2),
		.native_strobe(native_strobe)
	);

	rtg_pixel_fifo #(
		.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2),
		.BURST_LEN      (BURST_LEN)
	) u_fifo (
		.CLK_114  (CLK_114),
		.arst_n   (arst_n),
		.flush    (flush),
		.fill     (fill),
		.fill_data(fill_data),
		.pop      (pop),
		.fetch_req(fetch_req),
		.head_word(head_word)
	);

	rtg_colour_out u_colour (
		.CLK_114      (CLK_114),
		.arst_n       (arst_n),
		.rtg_ena      (rtg_ena),
		.blank_d2     (blank_d2),
		.pop          (pop),
		.native_strobe(native_strobe),
		.head_word    (head_word),
		.red          (red),
		.green        (green),
		.blue         (blue),
		.hs           (hs),
		.vs           (vs),
		.cs           (cs),
		.hsyncpol     (hsyncpol),
		.vsyncpol     (vsyncpol),
		.osd_window   (osd_window),
		.osd_pixel    (osd_pixel),
		.vga_pixel    (vga_pixel),
		.vga_r        (vga_r),
		.vga_g        (vga_g),
		.vga_b        (vga_b),
		.vga_hs       (vga_hs),
		.vga_vs       (vga_vs),
		.vga_cs       (vga_cs)
	);

endmodule

// File: tb/tb_rtg_model.svh
////////////////////////////////////////////////////////////////////////////
// Reference models for the RTG testbench, included in the testbench body.
// Random bits come from lfsr_state, one LFSR step per bit taken.
////////////////////////////////////////////////////////////////////////////
`ifndef TB_RTG_MODEL_SVH
`define TB_RTG_MODEL_SVH

logic [31:0] lfsr_state;                   // Seeded by the testbench

// Galois form, x^32 + x^22 + x^2 + x + 1, shifting right
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// Collect n random bits, LSB of the state each step
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v          = {v[30:0], lfsr_state[0]};
		lfsr_state = lfsr_next(lfsr_state);
	end
	return v;
endfunction

// RGB555 field to a VGA channel
function automatic logic [7:0] rgb5_to_8(input logic [4:0] f);
	return {f, f[4:2]};                    // Top three bits fill the bottom
endfunction

// OSD window rule for one channel
function automatic logic [7:0] osd_mix(input logic [7:0] c, input logic win,
		input logic pix, input logic is_blue);
	logic [1:0] top;
	top = pix ? 2'b11 : (is_blue ? 2'b10 : 2'b00);
	return win ? {top, c[7:2]} : c;
endfunction

`endif

// File: tb/tb_rtg_video_out.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the RTG display path, random frames from a fixed seed.
// FIFO depth and burst length here must match the DUT parameters.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_rtg_video_out;

	localparam int CLK_PERIOD      = 40;
	localparam int FIFO_DEPTH_LOG2 = 4;
	localparam int BURST_LEN       = 4;
	localparam int N_TESTS         = 5;
	localparam int FRAMES          = 2;
	localparam int LINES           = 12;       // Lines per frame
	localparam int VB_LINES        = 2;        // Chipset vblank lines
	localparam int LINE_MIN        = 64;       // Up to 31 clocks more
	localparam int WATCHDOG_CYCLES = N_TESTS * FRAMES * LINES * (LINE_MIN + 32) + 200;

	logic                CLK_114, arst_n;
	logic                rtg_ena, rtg_ext, scan_15khz;
	rtg_pkg::pix_width_t pixel_width;
	rtg_pkg::vb_lines_t  vb_end;
	rtg_pkg::chan_t      red, green, blue, vga_r, vga_g, vga_b;
	logic                hs, vs, cs, hsyncpol, vsyncpol, hblank, vblank;
	logic                osd_window, osd_pixel, fill, fetch_req, vga_pixel;
	logic                vga_hs, vga_vs, vga_cs;
	rtg_pkg::pix_word_t  fill_data;

	`include "tb_rtg_model.svh"

	logic        vbe, hs_prev, blank_prev;     // Timing model state
	logic [6:0]  vcnt;
	logic [3:0]  ctr;
	logic [2:0]  nat;
	logic        pop_d1, pop_d2, v_d1, v_d2;   // Pop to output, 2 clocks
	logic [15:0] w_d1, w_d2;
	logic [15:0] fifo_q[$];                    // Words the DUT should hold
	int          sent, gap;                    // Memory responder
	int          errors, checks, tests_failed, rtg_pixels;

	rtg_video_out #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2), .BURST_LEN(BURST_LEN))
		u_rtg_video_out (.*);

	initial begin
		CLK_114 = 1'b0;
		forever #(CLK_PERIOD / 2) CLK_114 = ~CLK_114;
	end

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		checks++;
		assert (got == exp) else begin
			$display("Fail %s got %h exp %h at %0t ns", name, got, exp, $time);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output checks, run at the falling edge before new inputs
	////////////////////////////////////////////////////////////////////////////

	task automatic check_outputs();
		logic [7:0] er, eg, eb;
		er = red;                                // Native colour, one clock old
		eg = green;
		eb = blue;
		check_value("vga_pixel", vga_pixel, rtg_ena ? pop_d2 : (nat == 3'd0));
		check_value("vga_hs", vga_hs, hsyncpol ^ hs);
		check_value("vga_vs", vga_vs, vsyncpol ^ vs);
		check_value("vga_cs", vga_cs, cs);
		if (vblank || !rtg_ena)
			check_value("fetch_req", fetch_req, 1'b0);
		if (rtg_ena && pop_d2 && v_d2) begin
			er = rgb5_to_8(w_d2[14:10]);
			eg = rgb5_to_8(w_d2[9:5]);
			eb = rgb5_to_8(w_d2[4:0]);
			rtg_pixels++;
		end
		if (!rtg_ena || (pop_d2 && v_d2)) begin
			check_value("vga_r", vga_r, osd_mix(er, osd_window, osd_pixel, 1'b0));
			check_value("vga_g", vga_g, osd_mix(eg, osd_window, osd_pixel, 1'b0));
			check_value("vga_b", vga_b, osd_mix(eb, osd_window, osd_pixel, 1'b1));
		end
	endtask

	// BURST_LEN fills per request, 0 to 2 idle clocks between them
	task automatic drive_responder();
		fill = 1'b0;
		if (!fetch_req) begin
			sent = 0;
			gap  = 0;
		end else begin
			assert (sent < BURST_LEN) else begin
				$display("fetch_req still high after a full burst at %0t ns", $time);
				errors++;
			end
			if (sent < BURST_LEN && gap == 0) begin
				fill      = 1'b1;
				fill_data = 16'(rand_bits(16));
				sent++;
				gap = rand_bits(2) % 3;
			end else if (gap > 0) begin
				gap--;
			end
		end
	endtask

	// Advance the model by the clock edge that follows
	task automatic step_model();
		logic        blank, pop, valid;
		logic [15:0] w;
		blank = vbe | hblank;
		pop   = rtg_ena && (!blank || (rtg_ext && !blank_prev)) && (ctr == pixel_width);
		ctr   = (blank || pop) ? 4'd0 : ctr + 4'd1;
		if (vblank) begin
			vbe  = 1'b1;
			vcnt = '0;
		end else if (vcnt == vb_end) begin
			vbe = 1'b0;
		end else if (hs && !hs_prev) begin
			vcnt = vcnt + 7'd1;                  // One more line of extension
		end
		blank_prev = blank;
		hs_prev    = hs;
		valid      = 1'b0;
		w          = '0;
		if (vblank || !rtg_ena) begin
			fifo_q.delete();                     // Flush drops all words
		end else begin
			if (pop) begin
				assert (fifo_q.size() != 0) else begin
					$display("Pixel fetch from an empty FIFO at %0t ns", $time);
					errors++;
				end
				if (fifo_q.size() != 0) begin
					w     = fifo_q.pop_front();
					valid = 1'b1;
				end
			end
			if (fill)
				fifo_q.push_back(fill_data);
			assert (fifo_q.size() <= 2 ** FIFO_DEPTH_LOG2) else begin
				$display("FIFO took more words than it can hold at %0t ns", $time);
				errors++;
			end
		end
		pop_d2 = pop_d1;
		pop_d1 = pop;
		v_d2   = v_d1;
		v_d1   = valid;
		w_d2   = w_d1;
		w_d1   = w;
		nat    = scan_15khz ? {nat[2:1], 1'b0} + 3'd2 : nat + 3'd1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One test is a few random frames in one mode
	////////////////////////////////////////////////////////////////////////////

	task automatic run_test(input int idx, input string name, input logic ena,
			input logic ext, input logic scan, input logic osd_en);
		int         line_len, hb_len, hs_len, err0;
		logic [3:0] pw;
		logic [6:0] vbl;
		err0       = errors;
		rtg_pixels = 0;
		pw         = 4'(3 + rand_bits(4) % 13);
		vbl        = 7'(1 + rand_bits(3) % 6);
		for (int f = 0; f < FRAMES; f++) begin
			for (int ln = 0; ln < LINES; ln++) begin
				line_len = LINE_MIN + rand_bits(5);
				hb_len   = 12 + rand_bits(3);
				hs_len   = 4 + rand_bits(2);
				for (int c = 0; c < line_len; c++) begin
					@(negedge CLK_114);
					check_outputs();
					if (f == 0 && ln == 0 && c == 0) begin   // New mode inside hblank
						rtg_ena     = ena;
						rtg_ext     = ext;
						scan_15khz  = scan;
						pixel_width = pw;
						vb_end      = vbl;
						hsyncpol    = rand_bits(1);
						vsyncpol    = rand_bits(1);
					end
					hblank = (c < hb_len);
					if (c == 1)
						vblank = (ln < VB_LINES);   // Only moves inside hblank
					hs         = (c >= 2) && (c < 2 + hs_len);
					vs         = (ln == 0);
					cs         = hs | vs;
					red        = 8'(rand_bits(8));
					green      = 8'(rand_bits(8));
					blue       = 8'(rand_bits(8));
					osd_window = osd_en && rand_bits(1);
					osd_pixel  = rand_bits(1);
					drive_responder();
					step_model();
				end
			end
		end
		assert (!ena || rtg_pixels > 0) else begin
			$display("No RTG pixels reached the output in test %0d", idx);
			errors++;
		end
		if (errors != err0)
			tests_failed++;
		$display("Test %0d %s: %s, %0d RTG pixels", idx, name,
			(errors == err0) ? "ok" : "errors", rtg_pixels);
	endtask

	initial begin
		lfsr_state = 32'ha063;
		arst_n     = 1'b0;
		rtg_ena    = 1'b1;
		rtg_ext    = 1'b0;
		scan_15khz = 1'b0;
		pixel_width = 4'd3;
		vb_end     = 7'd1;
		red        = '0;
		green      = '0;
		blue       = '0;
		hs         = 1'b0;
		vs         = 1'b0;
		cs         = 1'b0;
		hsyncpol   = 1'b0;
		vsyncpol   = 1'b0;
		hblank     = 1'b1;
		vblank     = 1'b1;
		osd_window = 1'b0;
		osd_pixel  = 1'b0;
		fill       = 1'b0;
		fill_data  = '0;
		{vbe, blank_prev} = 2'b11;             // Model reset state
		{hs_prev, pop_d1, pop_d2, v_d1, v_d2} = '0;
		{vcnt, ctr, nat, w_d1, w_d2} = '0;
		{sent, gap, errors, checks, tests_failed} = '0;
		repeat (4) @(negedge CLK_114);
		check_value("fetch_req", fetch_req, 1'b0);
		check_value("vga_pixel", vga_pixel, 1'b0);
		arst_n = 1'b1;
		drive_responder();
		step_model();
		run_test(0, "rgb555 order", 1'b1, 1'b0, 1'b0, 1'b0);
		run_test(1, "pacing with rtg_ext", 1'b1, 1'b1, 1'b0, 1'b0);
		run_test(2, "native 31 kHz", 1'b0, 1'b0, 1'b0, 1'b0);
		run_test(3, "native 15 kHz osd", 1'b0, 1'b0, 1'b1, 1'b1);
		run_test(4, "rtg osd overlay", 1'b1, 1'b1, 1'b0, 1'b1);
		$display("Tests %0d, failed %0d, checks %0d, errors %0d",
			N_TESTS, tests_failed, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Watchdog sized from the longest possible frames
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("** FAIL **");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+tb
design/rtg_pkg.sv
design/rtg_pixel_timing.sv
design/rtg_pixel_fifo.sv
design/rtg_colour_out.sv
design/rtg_video_out.sv
tb/tb_rtg_video_out.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the RTG testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module tb_rtg_video_out
out=$(./obj_dir/Vtb_rtg_video_out)
echo "$out"
if echo "$out" | grep -qF '** PASS **'; then
	exit 0
fi
exit 1
